// ==== common/acq_pkg.sv ====
package acq_pkg;

  // Word 1 in bits 79:64, word 5 in bits 15:0
  typedef logic [79:0] cmd_word_t;

  typedef logic [15:0] sample_t;

  typedef struct packed {
    logic almost_full;
    logic full;
    logic almost_empty;
    logic empty;
  } fifo_flags_t;

  // Status register bit layout, MSB first
  typedef struct packed {
    logic       cmd_almost_full;
    logic       cmd_full;
    logic       cmd_almost_empty;
    logic       cmd_empty;
    logic       smp_almost_full;
    logic       smp_full;
    logic       smp_empty;
    logic       smp_almost_empty;
    logic [7:0] reserved;
  } status_t;

endpackage

// ==== common/ebi_pkg.sv ====
package ebi_pkg;

  // --------------------------------------------------
  // Bus word types
  // --------------------------------------------------
  typedef logic [18:0] ebi_addr_t;
  typedef logic [15:0] ebi_data_t;

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------
  localparam ebi_addr_t ADDR_STATUS      = 19'd0;
  localparam ebi_addr_t ADDR_CMD_W1      = 19'd1;
  localparam ebi_addr_t ADDR_CMD_W2      = 19'd2;
  localparam ebi_addr_t ADDR_CMD_W3      = 19'd3;
  localparam ebi_addr_t ADDR_CMD_W4      = 19'd4;
  localparam ebi_addr_t ADDR_CMD_W5      = 19'd5;
  localparam ebi_addr_t ADDR_NEXT_SAMPLE = 19'd6;
  localparam ebi_addr_t ADDR_RESET_TIME  = 19'd7;
  localparam ebi_addr_t ADDR_RUN_TIME    = 19'd8;
  localparam ebi_addr_t ADDR_TIME_LO     = 19'd9;
  localparam ebi_addr_t ADDR_TIME_HI     = 19'd10;

  // Prefetch register contents before the first sample is fetched
  localparam ebi_data_t SAMPLE_RESET_VALUE = 16'hDEAD;

  // Host bus levels, sampled directly in the clk domain
  typedef struct packed {
    logic      cs;
    logic      rd;
    logic      wr;
    ebi_addr_t addr;
    ebi_data_t wdata;
  } bus_req_t;

endpackage

// ==== dv/tb_acq_core.sv ====
`timescale 1ns/1ps

module tb_acq_core;

  import ebi_pkg::*;
  import acq_pkg::*;

  localparam int CMD_DEPTH     = 4;
  localparam int SAMPLE_DEPTH  = 8;
  localparam int ALMOST_MARGIN = 1;
  localparam int WAIT_LIMIT    = 50;

  logic        clk;
  logic        rst;
  bus_req_t    bus;
  logic        cmd_pop;
  logic        sample_push;
  sample_t     sample_in;
  ebi_data_t   rdata;
  logic        irq;
  logic [31:0] global_clock;
  cmd_word_t   cmd_out;
  fifo_flags_t cmd_flags;

  // Reference model state
  cmd_word_t cmd_model [$];
  sample_t   smp_model [$];
  sample_t   prefetch_model;
  integer    seed;

  acq_core_top #(
    .CMD_DEPTH     (CMD_DEPTH),
    .SAMPLE_DEPTH  (SAMPLE_DEPTH),
    .ALMOST_MARGIN (ALMOST_MARGIN)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .bus          (bus),
    .cmd_pop      (cmd_pop),
    .sample_push  (sample_push),
    .sample_in    (sample_in),
    .rdata        (rdata),
    .irq          (irq),
    .global_clock (global_clock),
    .cmd_out      (cmd_out),
    .cmd_flags    (cmd_flags)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------
  // Reference functions and checking
  // --------------------------------------------------
  function automatic cmd_word_t expected_command(input logic [4:0][15:0] words);
    return {words[0], words[1], words[2], words[3], words[4]};
  endfunction

  function automatic logic [15:0] expected_status(input int cmd_cnt, input int smp_cnt);
    logic [15:0] s;
    s     = '0;
    s[15] = (cmd_cnt >= CMD_DEPTH - ALMOST_MARGIN);
    s[14] = (cmd_cnt == CMD_DEPTH);
    s[13] = (cmd_cnt <= ALMOST_MARGIN);
    s[12] = (cmd_cnt == 0);
    s[11] = (smp_cnt >= SAMPLE_DEPTH - ALMOST_MARGIN);
    s[10] = (smp_cnt == SAMPLE_DEPTH);
    // Sample side has empty above almost_empty
    s[9]  = (smp_cnt == 0);
    s[8]  = (smp_cnt <= ALMOST_MARGIN);
    return s;
  endfunction

  task automatic check_value(input string name, input logic [79:0] expected,
                             input logic [79:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s expected %0h actual %0h", name, expected, actual);
      $display("Regression failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
    $display("Regression failed");
    $fatal(1, "wait expired");
  endtask

  // Every popped command is compared with the model head
  always @(posedge clk) begin
    if (!rst && cmd_pop && cmd_model.size() != 0) begin
      check_value("cmd_order", cmd_model[0], cmd_out);
      void'(cmd_model.pop_front());
    end
  end

  // --------------------------------------------------
  // Bus and FIFO side tasks
  // --------------------------------------------------
  task automatic bus_write(input ebi_addr_t addr, input ebi_data_t data);
    bus_req_t req;
    req       = '0;
    req.cs    = 1'b1;
    req.wr    = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    @(posedge clk);
    bus <= req;
    repeat (3) @(posedge clk);
    bus <= '0;
    repeat (3) @(posedge clk);
  endtask

  task automatic bus_read(input ebi_addr_t addr, output ebi_data_t data);
    bus_req_t req;
    req      = '0;
    req.cs   = 1'b1;
    req.rd   = 1'b1;
    req.addr = addr;
    @(posedge clk);
    bus <= req;
    repeat (2) @(posedge clk);
    @(negedge clk);
    data = rdata;
    @(posedge clk);
    bus <= '0;
    repeat (3) @(posedge clk);
  endtask

  task automatic wait_irq(input logic level, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (irq !== level) begin
      if (cycles == WAIT_LIMIT) begin
        timeout_fail(what);
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic send_command();
    logic [4:0][15:0] words;
    for (int i = 0; i < 5; i++) begin
      words[i] = 16'($random(seed));
      bus_write(ADDR_CMD_W1 + ebi_addr_t'(i), words[i]);
    end
    // A full command FIFO drops the word
    if (cmd_model.size() < CMD_DEPTH) begin
      cmd_model.push_back(expected_command(words));
    end
  endtask

  task automatic pop_command();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (cmd_flags.empty) begin
      if (cycles == WAIT_LIMIT) begin
        timeout_fail("command FIFO not empty");
      end
      cycles++;
      @(negedge clk);
    end
    @(posedge clk);
    cmd_pop <= 1'b1;
    @(posedge clk);
    cmd_pop <= 1'b0;
    @(negedge clk);
  endtask

  task automatic push_sample();
    sample_t value;
    value = 16'($random(seed));
    @(posedge clk);
    sample_push <= 1'b1;
    sample_in   <= value;
    @(posedge clk);
    sample_push <= 1'b0;
    if (smp_model.size() < SAMPLE_DEPTH) begin
      smp_model.push_back(value);
    end
  endtask

  task automatic read_sample(input string name);
    ebi_data_t got;
    bus_read(ADDR_NEXT_SAMPLE, got);
    check_value(name, 80'(prefetch_model), 80'(got));
    // Bridge refills prefetch from the FIFO head
    if (smp_model.size() != 0) begin
      prefetch_model = smp_model.pop_front();
    end
  endtask

  task automatic read_status(input string name);
    ebi_data_t   got;
    logic [15:0] exp_status;
    bus_read(ADDR_STATUS, got);
    exp_status = expected_status(cmd_model.size(), smp_model.size());
    check_value(name, 80'(exp_status), 80'(got));
  endtask

  task automatic read_time(output logic [31:0] value);
    ebi_data_t lo;
    ebi_data_t hi;
    bus_read(ADDR_TIME_LO, lo);
    bus_read(ADDR_TIME_HI, hi);
    value = {hi, lo};
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] t1;
    logic [31:0] t2;
    logic [15:0] exp_status;
    seed           = 32'h46960240;
    prefetch_model = 16'hDEAD;
    rst            <= 1'b1;
    bus            <= '0;
    cmd_pop        <= 1'b0;
    sample_push    <= 1'b0;
    sample_in      <= '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("reset_rdata", 80'(0), 80'(rdata));
    check_value("reset_irq", 80'(0), 80'(irq));

    // Status leaves its reset value, so irq rises once
    wait_irq(1'b1, "irq after reset");
    read_status("status_after_reset");
    wait_irq(1'b0, "irq clear after first status read");

    // Flag change holds irq until status is read
    push_sample();
    wait_irq(1'b1, "irq on sample push");
    repeat (5) begin
      @(negedge clk);
      check_value("irq_held", 80'(1), 80'(irq));
    end
    read_status("status_after_push");
    wait_irq(1'b0, "irq clear after second status read");

    // Samples come back in push order behind the reset value
    repeat (4) push_sample();
    read_sample("sample_reset_value");
    repeat (4) read_sample("sample_order");
    read_status("status_samples_drained");

    repeat (3) send_command();
    repeat (3) pop_command();
    exp_status = expected_status(0, 0);
    check_value("cmd_drained", 80'(exp_status[15:12]), 80'(cmd_flags));

    // Fifth command overflows a four deep FIFO
    repeat (5) send_command();
    read_status("status_cmd_full");
    exp_status = expected_status(CMD_DEPTH, 0);
    check_value("cmd_flags_full", 80'(exp_status[15:12]), 80'(cmd_flags));
    repeat (4) pop_command();
    exp_status = expected_status(0, 0);
    check_value("cmd_flags_empty", 80'(exp_status[15:12]), 80'(cmd_flags));

    // Global time counter
    bus_write(ADDR_RUN_TIME, 16'h0001);
    read_time(t1);
    read_time(t2);
    check_value("time_growing", 80'(1), 80'(t2 > t1));
    bus_write(ADDR_RUN_TIME, 16'h0000);
    read_time(t1);
    read_time(t2);
    check_value("time_stopped", 80'(t1), 80'(t2));
    bus_write(ADDR_RESET_TIME, 16'h0000);
    read_time(t1);
    check_value("time_cleared", 80'(0), 80'(t1));
    @(negedge clk);
    check_value("time_port_cleared", 80'(0), 80'(global_clock));

    $display("Regression passed");
    $finish;
  end

endmodule

// ==== ebi/ebi_bridge.sv ====
`timescale 1ns/1ps

module ebi_bridge (
  input  logic               clk,
  input  logic               rst,
  input  ebi_pkg::bus_req_t  bus,
  input  acq_pkg::sample_t   sample_head,
  input  acq_pkg::status_t   status,
  input  logic [31:0]        global_clock,
  output ebi_pkg::ebi_data_t rdata,
  output logic               cmd_push,
  output acq_pkg::cmd_word_t cmd_data,
  output logic               sample_pop,
  output logic               status_read,
  output logic               time_clear,
  output logic               run_write,
  output logic               run_value
);

  import ebi_pkg::*;
  import acq_pkg::*;

  typedef enum logic [5:0] {
    idle           = 6'b000001,
    fetch          = 6'b000010,
    fifo_load      = 6'b000100,
    trans_over     = 6'b001000,
    fifo_read      = 6'b010000,
    fifo_read_next = 6'b100000
  } state_t;

  state_t    state;
  state_t    next_state;
  ebi_data_t cap_q [5];
  sample_t   prefetch_q;
  logic      wr_sel;
  logic      rd_sel;
  logic      in_fetch;
  logic      rd_d;
  logic      rd_dd;
  logic      rd_done;

  assign wr_sel   = bus.cs && bus.wr;
  assign rd_sel   = bus.cs && bus.rd;
  assign in_fetch = (state == fetch);

  // --------------------------------------------------
  // Control FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      idle:           next_state = fetch;
      fetch: begin
        if (wr_sel && bus.addr == ADDR_CMD_W5) begin
          next_state = fifo_load;
        end else if (rd_sel && bus.addr == ADDR_NEXT_SAMPLE) begin
          next_state = fifo_read;
        end
      end
      fifo_load:      next_state = trans_over;
      trans_over: begin
        if (!bus.rd && !bus.wr) begin
          next_state = fetch;
        end
      end
      // Hold until the host has dropped rd
      fifo_read: begin
        if (rd_done) begin
          next_state = fifo_read_next;
        end
      end
      fifo_read_next: next_state = fetch;
      default:        next_state = idle;
    endcase
  end

  // Strobes towards the FIFOs and the register block
  assign cmd_push    = (state == fifo_load);
  assign sample_pop  = (state == fifo_read_next);
  assign status_read = in_fetch && rd_sel && (bus.addr == ADDR_STATUS);
  assign time_clear  = in_fetch && wr_sel && (bus.addr == ADDR_RESET_TIME);
  assign run_write   = in_fetch && wr_sel && (bus.addr == ADDR_RUN_TIME);
  assign run_value   = bus.wdata[0];

  // --------------------------------------------------
  // Command word capture
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (in_fetch && wr_sel) begin
      case (bus.addr)
        ADDR_CMD_W1: cap_q[0] <= bus.wdata;
        ADDR_CMD_W2: cap_q[1] <= bus.wdata;
        ADDR_CMD_W3: cap_q[2] <= bus.wdata;
        ADDR_CMD_W4: cap_q[3] <= bus.wdata;
        ADDR_CMD_W5: cap_q[4] <= bus.wdata;
        default:     ;
      endcase
    end
  end

  assign cmd_data = {cap_q[0], cap_q[1], cap_q[2], cap_q[3], cap_q[4]};

  // --------------------------------------------------
  // Sample prefetch and read data
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      prefetch_q <= SAMPLE_RESET_VALUE;
      rdata      <= '0;
    end else begin
      // Head is taken on the same edge that pops it
      if (sample_pop) begin
        prefetch_q <= sample_head;
      end
      if (in_fetch && rd_sel) begin
        case (bus.addr)
          ADDR_STATUS:      rdata <= ebi_data_t'(status);
          ADDR_NEXT_SAMPLE: rdata <= prefetch_q;
          ADDR_TIME_LO:     rdata <= global_clock[15:0];
          ADDR_TIME_HI:     rdata <= global_clock[31:16];
          default:          ;
        endcase
      end
    end
  end

  // rd falling edge through two delay stages
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_d  <= 1'b0;
      rd_dd <= 1'b0;
    end else begin
      rd_d  <= rd_sel;
      rd_dd <= rd_d;
    end
  end

  assign rd_done = rd_dd && !rd_d;

  a_state_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot(state));

  a_single_push: assert property (@(posedge clk) disable iff (rst)
    cmd_push |=> !cmd_push);

endmodule

// ==== ebi/ebi_status_regs.sv ====
`timescale 1ns/1ps

module ebi_status_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  acq_pkg::fifo_flags_t cmd_flags,
  input  acq_pkg::fifo_flags_t sample_flags,
  input  logic                 status_read,
  input  logic                 time_clear,
  input  logic                 run_write,
  input  logic                 run_value,
  output acq_pkg::status_t     status,
  output logic                 irq,
  output logic [31:0]          global_clock
);

  import acq_pkg::*;

  status_t status_next;
  status_t snap_q;
  logic    run_q;

  // --------------------------------------------------
  // Status, snapshot and interrupt
  // --------------------------------------------------
  always_comb begin
    status_next                  = '0;
    status_next.cmd_almost_full  = cmd_flags.almost_full;
    status_next.cmd_full         = cmd_flags.full;
    status_next.cmd_almost_empty = cmd_flags.almost_empty;
    status_next.cmd_empty        = cmd_flags.empty;
    // Sample FIFO has empty ahead of almost_empty
    status_next.smp_almost_full  = sample_flags.almost_full;
    status_next.smp_full         = sample_flags.full;
    status_next.smp_empty        = sample_flags.empty;
    status_next.smp_almost_empty = sample_flags.almost_empty;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      status <= '0;
      snap_q <= '0;
      irq    <= 1'b0;
    end else begin
      status <= status_next;
      if (status_read) begin
        snap_q <= status;
      end
      irq <= (status != snap_q);
    end
  end

  // --------------------------------------------------
  // Global time counter
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      run_q        <= 1'b0;
      global_clock <= '0;
    end else begin
      if (run_write) begin
        run_q <= run_value;
      end
      if (time_clear) begin
        global_clock <= '0;
      end else if (run_q) begin
        global_clock <= global_clock + 32'd1;
      end
    end
  end

  // A status read with a steady status clears irq
  a_irq_clear: assert property (@(posedge clk) disable iff (rst)
    $past(status_read) && $stable(status) |=> !irq);

endmodule

// ==== project.f ====
common/ebi_pkg.sv
common/acq_pkg.sv
rtl/sync_fifo.sv
ebi/ebi_bridge.sv
ebi/ebi_status_regs.sv
rtl/acq_core_top.sv
dv/tb_acq_core.sv

// ==== rtl/acq_core_top.sv ====
`timescale 1ns/1ps

module acq_core_top #(
  parameter int CMD_DEPTH     = 4,
  parameter int SAMPLE_DEPTH  = 8,
  parameter int ALMOST_MARGIN = 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  ebi_pkg::bus_req_t    bus,
  input  logic                 cmd_pop,
  input  logic                 sample_push,
  input  acq_pkg::sample_t     sample_in,
  output ebi_pkg::ebi_data_t   rdata,
  output logic                 irq,
  output logic [31:0]          global_clock,
  output acq_pkg::cmd_word_t   cmd_out,
  output acq_pkg::fifo_flags_t cmd_flags
);

  import acq_pkg::*;

  cmd_word_t   cmd_data;
  logic        cmd_push;
  sample_t     sample_head;
  logic        sample_pop;
  fifo_flags_t sample_flags;
  status_t     status;
  logic        status_read;
  logic        time_clear;
  logic        run_write;
  logic        run_value;

  // --------------------------------------------------
  // Bus side
  // --------------------------------------------------
  ebi_bridge u_bridge (
    .clk          (clk),
    .rst          (rst),
    .bus          (bus),
    .sample_head  (sample_head),
    .status       (status),
    .global_clock (global_clock),
    .rdata        (rdata),
    .cmd_push     (cmd_push),
    .cmd_data     (cmd_data),
    .sample_pop   (sample_pop),
    .status_read  (status_read),
    .time_clear   (time_clear),
    .run_write    (run_write),
    .run_value    (run_value)
  );

  ebi_status_regs u_regs (
    .clk          (clk),
    .rst          (rst),
    .cmd_flags    (cmd_flags),
    .sample_flags (sample_flags),
    .status_read  (status_read),
    .time_clear   (time_clear),
    .run_write    (run_write),
    .run_value    (run_value),
    .status       (status),
    .irq          (irq),
    .global_clock (global_clock)
  );

  // --------------------------------------------------
  // Command and sample FIFOs
  // --------------------------------------------------
  sync_fifo #(
    .payload_t     (cmd_word_t),
    .DEPTH         (CMD_DEPTH),
    .ALMOST_MARGIN (ALMOST_MARGIN)
  ) u_cmd_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (cmd_push),
    .din   (cmd_data),
    .pop   (cmd_pop),
    .dout  (cmd_out),
    .flags (cmd_flags)
  );

  sync_fifo #(
    .payload_t     (sample_t),
    .DEPTH         (SAMPLE_DEPTH),
    .ALMOST_MARGIN (ALMOST_MARGIN)
  ) u_sample_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (sample_push),
    .din   (sample_in),
    .pop   (sample_pop),
    .dout  (sample_head),
    .flags (sample_flags)
  );

endmodule

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t     = logic [15:0],
  parameter int  DEPTH         = 4,
  parameter int  ALMOST_MARGIN = 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push,
  input  payload_t             din,
  input  logic                 pop,
  output payload_t             dout,
  output acq_pkg::fifo_flags_t flags
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(DEPTH);
  localparam logic [CNT_W-1:0] AF_CNT    = CNT_W'(DEPTH - ALMOST_MARGIN);
  localparam logic [CNT_W-1:0] AE_CNT    = CNT_W'(ALMOST_MARGIN);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Drop pushes when full, ignore pops when empty
  assign do_push = push && !flags.full;
  assign do_pop  = pop && !flags.empty;

  // --------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Head of queue, first word fall through
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------------------
  // Flags from occupancy
  // --------------------------------------------------
  assign flags.empty        = (count == '0);
  assign flags.full         = (count == FULL_CNT);
  assign flags.almost_empty = (count <= AE_CNT);
  assign flags.almost_full  = (count >= AF_CNT);

  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= FULL_CNT);

  a_full_empty_excl: assert property (@(posedge clk) disable iff (rst)
    !(flags.full && flags.empty));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_acq_core -f project.f -Mdir obj_dir -o tb_acq_core

./obj_dir/tb_acq_core | tee sim.log

if grep -q "Regression passed" sim.log; then
  echo "Simulation PASS"
  exit 0
else
  echo "Simulation FAIL"
  exit 1
fi
